// File: Makefile
SIM        = verilator
TOP        = tb_lvds_rx_top
FILELIST   = all.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
PASS_MSG   = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
src/lvds_rx_pkg.sv
src/lvds_video_if.sv
src/rx_lock_holdoff.sv
src/lvds_pixel_unpack.sv
src/lvds_rx_top.sv
testbench/lvds_rx_props.sv
testbench/tb_lvds_rx_top.sv

// File: src/lvds_pixel_unpack.sv
`timescale 1ns/100ps
`default_nettype none

module lvds_pixel_unpack import lvds_rx_pkg::*; (
    input  wire logic        deser_clk,
    input  wire logic        c3_sys_rst_i,
    input  wire logic        i_lvds_rst,
    input  wire deser_word_t i_deser_data,
    lvds_video_if.source     video
);

    // The color bits of a lane are scattered over the serial slots.
    // Offsets below are relative to the start of the lane.
    function automatic rgb_pixel_t unpack_lane(input logic [LANE_WIDTH-1:0] lane);
        logic [PIXEL_WIDTH-1:0] flat;
        flat = {
            lane[26:25], lane[17:14], lane[13:12],  // Blue
            lane[24:23], lane[11:7],  lane[6],      // Green
            lane[22:21], lane[5:0]                  // Red
        };
        return rgb_pixel_t'(flat);
    endfunction

    logic [LANE_WIDTH-1:0] lane0;
    logic [LANE_WIDTH-1:0] lane1;
    rgb_pixel_t            pixel_first_d;
    rgb_pixel_t            pixel_second_d;
    logic                  de_d;
    logic                  hsync_d;
    logic                  vsync_d;

    assign lane0 = i_deser_data[0 +: LANE_WIDTH];
    assign lane1 = i_deser_data[LANE_WIDTH +: LANE_WIDTH];

    always_comb begin
        pixel_first_d  = unpack_lane(lane0);
        pixel_second_d = unpack_lane(lane1);
    end

    // Syncs come from lane 0 only and are active low on the link
    always_comb begin
        de_d    = ~i_deser_data[DE_BIT];
        hsync_d = ~i_deser_data[HS_BIT];
        vsync_d = ~i_deser_data[VS_BIT];
    end

    // Output register held at zero while the video reset is up
    always_ff @(posedge deser_clk or posedge c3_sys_rst_i or posedge i_lvds_rst) begin
        if (c3_sys_rst_i || i_lvds_rst) begin
            video.pixel_first  <= '0;
            video.pixel_second <= '0;
            video.de           <= 1'b0;
            video.hsync        <= 1'b0;
            video.vsync        <= 1'b0;
        end else begin
            video.pixel_first  <= pixel_first_d;
            video.pixel_second <= pixel_second_d;
            video.de           <= de_d;
            video.hsync        <= hsync_d;
            video.vsync        <= vsync_d;
        end
    end

endmodule : lvds_pixel_unpack

`default_nettype wire

// File: src/lvds_rx_pkg.sv
`default_nettype none

package lvds_rx_pkg;

    // Deserializer word of two lanes side by side
    localparam int DESER_WIDTH  = 56;
    localparam int LANE_WIDTH   = 28;   // Also the bit offset of lane 1
    localparam int PIXEL_WIDTH  = 24;

    // PLL lock qualification
    localparam int HOLDOFF_BITS = 16;   // Counts to all ones before release
    localparam int SYNC_STAGES  = 2;    // Video reset synchronizer depth

    // Active-low sync positions in lane 0
    localparam int DE_BIT       = 20;
    localparam int HS_BIT       = 18;
    localparam int VS_BIT       = 19;

    // Lane 1 carries its own copies of the syncs at
    // LANE_WIDTH + 18..20, which the receiver does not use

    typedef logic [DESER_WIDTH-1:0] deser_word_t;

    // One RGB888 pixel with blue in the top byte
    typedef struct packed {
        logic [7:0] blue;
        logic [7:0] green;
        logic [7:0] red;
    } rgb_pixel_t;

    // Lock hold-off FSM
    typedef enum logic {
        HOLD_COUNTING = 1'b0,
        HOLD_READY    = 1'b1
    } holdoff_state_e;

endpackage : lvds_rx_pkg

`default_nettype wire

// File: src/lvds_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module lvds_rx_top import lvds_rx_pkg::*; (
    input  wire logic        deser_clk,
    input  wire logic        c3_sys_rst_i,
    input  wire logic        i_rx_bufpll_lock,
    input  wire deser_word_t i_deser_data,

    output logic             o_lvds_rst,
    output rgb_pixel_t       o_pixel_first,
    output rgb_pixel_t       o_pixel_second,
    output logic             o_de,
    output logic             o_hsync,
    output logic             o_vsync
);

    logic lvds_rst;     // Synchronized video reset

    lvds_video_if video_if ();

    // Lock qualification and video reset
    rx_lock_holdoff rx_lock_holdoff_inst (
        .deser_clk        (deser_clk),
        .c3_sys_rst_i     (c3_sys_rst_i),
        .i_rx_bufpll_lock (i_rx_bufpll_lock),
        .o_lvds_rst       (lvds_rst)
    );

    lvds_pixel_unpack lvds_pixel_unpack_inst (
        .deser_clk    (deser_clk),
        .c3_sys_rst_i (c3_sys_rst_i),
        .i_lvds_rst   (lvds_rst),
        .i_deser_data (i_deser_data),
        .video        (video_if.source)
    );

    assign o_lvds_rst = lvds_rst;

    // Video bundle out to plain ports
    assign o_pixel_first  = video_if.pixel_first;
    assign o_pixel_second = video_if.pixel_second;
    assign o_de           = video_if.de;
    assign o_hsync        = video_if.hsync;
    assign o_vsync        = video_if.vsync;

endmodule : lvds_rx_top

`default_nettype wire

// File: src/lvds_video_if.sv
`timescale 1ns/100ps
`default_nettype none

// Unpacked video bundle with two pixels per deser_clk cycle
interface lvds_video_if import lvds_rx_pkg::*; ();

    rgb_pixel_t pixel_first;    // From lane 0
    rgb_pixel_t pixel_second;   // From lane 1
    logic       de;             // Active high here
    logic       hsync;
    logic       vsync;

    modport source (
        output pixel_first,
        output pixel_second,
        output de,
        output hsync,
        output vsync
    );

    modport sink (
        input pixel_first,
        input pixel_second,
        input de,
        input hsync,
        input vsync
    );

endinterface : lvds_video_if

`default_nettype wire

// File: src/rx_lock_holdoff.sv
`timescale 1ns/100ps
`default_nettype none

module rx_lock_holdoff import lvds_rx_pkg::*; (
    input  wire logic deser_clk,
    input  wire logic c3_sys_rst_i,
    input  wire logic i_rx_bufpll_lock,
    output logic      o_lvds_rst
);

    logic [HOLDOFF_BITS-1:0] holdoff_cnt;
    holdoff_state_e          holdoff_state;
    logic [SYNC_STAGES-1:0]  rst_sync;     // Bit 0 is the first stage
    logic                    not_ready;

    // Wait for the receive PLL to stay locked for a full counter span.
    // Losing lock at any point restarts the wait from zero.
    always_ff @(posedge deser_clk or posedge c3_sys_rst_i or negedge i_rx_bufpll_lock) begin
        if (c3_sys_rst_i || !i_rx_bufpll_lock) begin
            holdoff_cnt   <= '0;
            holdoff_state <= HOLD_COUNTING;
        end else begin
            case (holdoff_state)
                HOLD_COUNTING: begin
                    holdoff_cnt <= holdoff_cnt + 1'b1;
                    if (&holdoff_cnt) begin     // Old count all ones
                        holdoff_state <= HOLD_READY;
                    end
                end
                HOLD_READY: begin
                    holdoff_state <= HOLD_READY;    // Counter frozen
                end
                default: begin
                    holdoff_state <= HOLD_COUNTING;
                end
            endcase
        end
    end

    assign not_ready = (holdoff_state != HOLD_READY);

    // Video reset asserts at once and releases after SYNC_STAGES edges
    always_ff @(posedge deser_clk or posedge c3_sys_rst_i or negedge i_rx_bufpll_lock) begin
        if (c3_sys_rst_i || !i_rx_bufpll_lock) begin
            rst_sync <= '1;
        end else begin
            rst_sync <= {rst_sync[SYNC_STAGES-2:0], not_ready};
        end
    end

    assign o_lvds_rst = rst_sync[SYNC_STAGES-1];

endmodule : rx_lock_holdoff

`default_nettype wire

// File: testbench/lvds_rx_props.sv
`timescale 1ns/100ps
`default_nettype none

module lvds_rx_props import lvds_rx_pkg::*; (
    input wire logic        deser_clk,
    input wire logic        c3_sys_rst_i,
    input wire logic        i_rx_bufpll_lock,
    input wire deser_word_t i_deser_data,
    input wire logic        o_lvds_rst,
    input wire rgb_pixel_t  o_pixel_first,
    input wire rgb_pixel_t  o_pixel_second,
    input wire logic        o_de,
    input wire logic        o_hsync,
    input wire logic        o_vsync
);

    // Bundle stays cleared under the video reset
    assert property (@(posedge deser_clk) disable iff (c3_sys_rst_i)
        o_lvds_rst |-> (o_pixel_first == '0 && o_pixel_second == '0 &&
                        !o_de && !o_hsync && !o_vsync))
    else $error("Video outputs not zero while video reset is high");

    assert property (@(posedge deser_clk) disable iff (c3_sys_rst_i)
        !i_rx_bufpll_lock |=> o_lvds_rst)
    else $error("Video reset low after lock loss");

    // DE follows inverted lane 0 bit 20 one cycle later
    assert property (@(posedge deser_clk) disable iff (c3_sys_rst_i)
        (!o_lvds_rst && $past(!o_lvds_rst) && i_rx_bufpll_lock) |->
        (o_de == !$past(i_deser_data[DE_BIT])))
    else $error("o_de does not match previous data word");

endmodule : lvds_rx_props

bind lvds_rx_top lvds_rx_props lvds_rx_props_inst (
    .deser_clk        (deser_clk),
    .c3_sys_rst_i     (c3_sys_rst_i),
    .i_rx_bufpll_lock (i_rx_bufpll_lock),
    .i_deser_data     (i_deser_data),
    .o_lvds_rst       (o_lvds_rst),
    .o_pixel_first    (o_pixel_first),
    .o_pixel_second   (o_pixel_second),
    .o_de             (o_de),
    .o_hsync          (o_hsync),
    .o_vsync          (o_vsync)
);

`default_nettype wire

// File: testbench/tb_lvds_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lvds_rx_top import lvds_rx_pkg::*; ();

    typedef struct packed {
        deser_word_t word;
        rgb_pixel_t  first;
        rgb_pixel_t  second;
        logic        de;
        logic        hsync;
        logic        vsync;
    } vector_t;

    logic        deser_clk;
    logic        c3_sys_rst_i;
    logic        i_rx_bufpll_lock;
    deser_word_t i_deser_data;
    logic        o_lvds_rst;
    rgb_pixel_t  o_pixel_first;
    rgb_pixel_t  o_pixel_second;
    logic        o_de;
    logic        o_hsync;
    logic        o_vsync;

    vector_t vectors [8];
    integer  seed;

    lvds_rx_top lvds_rx_top_inst (
        .deser_clk        (deser_clk),
        .c3_sys_rst_i     (c3_sys_rst_i),
        .i_rx_bufpll_lock (i_rx_bufpll_lock),
        .i_deser_data     (i_deser_data),
        .o_lvds_rst       (o_lvds_rst),
        .o_pixel_first    (o_pixel_first),
        .o_pixel_second   (o_pixel_second),
        .o_de             (o_de),
        .o_hsync          (o_hsync),
        .o_vsync          (o_vsync)
    );

    initial deser_clk = 1'b0;
    always #5 deser_clk = ~deser_clk;   // 10 ns period

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Output check failed");
        end
    endtask

    // Source bits of each color from the MSB down relative to the lane base
    function automatic rgb_pixel_t expected_pixel(input deser_word_t word, input int base);
        int         blue_pos [8];
        int         green_pos [8];
        int         red_pos [8];
        rgb_pixel_t pix;
        blue_pos  = '{26, 25, 17, 16, 15, 14, 13, 12};
        green_pos = '{24, 23, 11, 10, 9, 8, 7, 6};
        red_pos   = '{22, 21, 5, 4, 3, 2, 1, 0};
        for (int i = 0; i < 8; i++) begin
            pix.blue[7-i]  = word[base + blue_pos[i]];
            pix.green[7-i] = word[base + green_pos[i]];
            pix.red[7-i]   = word[base + red_pos[i]];
        end
        return pix;
    endfunction

    function automatic vector_t make_entry(input deser_word_t word);
        vector_t entry;
        entry.word   = word;
        entry.first  = expected_pixel(word, 0);
        entry.second = expected_pixel(word, LANE_WIDTH);
        entry.de     = ~word[DE_BIT];   // Lane 0 syncs only
        entry.hsync  = ~word[HS_BIT];
        entry.vsync  = ~word[VS_BIT];
        return entry;
    endfunction

    function automatic deser_word_t random_word();
        logic [63:0] raw;
        raw = {$random(seed), $random(seed)};
        return raw[DESER_WIDTH-1:0];
    endfunction

    task automatic check_outputs(input logic exp_rst, input vector_t exp);
        check_value("o_lvds_rst", 32'(o_lvds_rst), 32'(exp_rst));
        check_value("o_pixel_first", 32'(o_pixel_first), 32'(exp.first));
        check_value("o_pixel_second", 32'(o_pixel_second), 32'(exp.second));
        check_value("o_de", 32'(o_de), 32'(exp.de));
        check_value("o_hsync", 32'(o_hsync), 32'(exp.hsync));
        check_value("o_vsync", 32'(o_vsync), 32'(exp.vsync));
    endtask

    task automatic check_idle();
        check_outputs(1'b1, '0);    // Video reset up and bundle cleared
    endtask

    // Counts edges from the release of reset or lock
    task automatic run_holdoff();
        int release_edge;
        release_edge = (1 << HOLDOFF_BITS) + SYNC_STAGES;
        for (int edge_num = 1; edge_num <= release_edge; edge_num++) begin
            i_deser_data = random_word();
            @(negedge deser_clk);
            check_outputs((edge_num == release_edge) ? 1'b0 : 1'b1, '0);
        end
    endtask

    task automatic apply_entry(input vector_t entry);
        i_deser_data = entry.word;
        @(negedge deser_clk);
        check_outputs(1'b0, entry);     // One cycle latency
    endtask

    task automatic apply_table();
        foreach (vectors[i]) begin
            apply_entry(vectors[i]);
        end
    endtask

    task automatic drop_lock();
        i_rx_bufpll_lock = 1'b0;
        #1;
        check_idle();                   // Asynchronous assertion
        repeat (5) begin
            @(negedge deser_clk);
            i_deser_data = random_word();
            check_idle();
        end
        i_rx_bufpll_lock = 1'b1;
    endtask

    initial begin
        seed             = 43;
        c3_sys_rst_i     = 1'b1;
        i_rx_bufpll_lock = 1'b1;
        i_deser_data     = '0;

        vectors[0] = make_entry('1);
        vectors[1] = make_entry('0);
        vectors[2] = make_entry(deser_word_t'(1));
        vectors[3] = make_entry(deser_word_t'(1) << 26);
        vectors[4] = make_entry({28'hFFF_FFFF, 28'h000_0000});     // Lane 1 only
        vectors[5] = make_entry(deser_word_t'(7) << HS_BIT);       // Sync bits only
        vectors[6] = make_entry(deser_word_t'(7) << (LANE_WIDTH + HS_BIT));
        vectors[7] = make_entry(56'hA5_5A3C_C396_0F1E);

        repeat (10) begin
            i_deser_data = random_word();
            @(negedge deser_clk);
            check_idle();
        end
        c3_sys_rst_i = 1'b0;

        run_holdoff();
        apply_table();
        repeat (200) begin
            apply_entry(make_entry(random_word()));
        end

        // Lock loss restarts the full hold-off
        drop_lock();
        run_holdoff();
        apply_table();

        $display("Test completed successfully");
        $finish;
    end

    // Two hold-off periods, reset, table passes and random words
    initial begin
        longint limit_cycles;
        limit_cycles = 2 * ((longint'(1) << HOLDOFF_BITS) + SYNC_STAGES) + 10 + 2 * 8 + 200 + 6;
        limit_cycles = limit_cycles + limit_cycles / 4;     // Margin
        #(limit_cycles * 10);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

endmodule : tb_lvds_rx_top

`default_nettype wire
